// ==== filelist.f ====
+incdir+test
src/pwm_regs_pkg.sv
src/pwm_types_pkg.sv
src/pwm_ctrl_if.sv
src/pwm_control_unit.sv
src/timebase_generator.sv
src/pwm_chain.sv
src/pwm_output_stage.sv
src/pwm_generator.sv
test/pwm_generator_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = pwm_generator_tb
FILELIST = filelist.f
SIM      = obj_dir/V$(TOP)

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

// ==== test/pwm_tb_model.svh ====
// PWM generator reference model
// LFSR stimulus source, register model and expected pwm_out of the output stage
`ifndef PWM_TB_MODEL_SVH
`define PWM_TB_MODEL_SVH

// Fibonacci LFSR with taps 32, 22, 2 and 1
logic [31:0] lfsr_state = 32'hb055_1a3c;

function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
endfunction

// One LFSR step per bit taken, the newest bit lands in the LSB
function automatic int unsigned draw_bits(input int count);
    int unsigned value;
    value = 0;
    for (int i = 0; i < count; i++) begin
        lfsr_state = lfsr_next(lfsr_state);
        value = (value << 1) | lfsr_state[0];
    end
    return value;
endfunction

// Register model, holds what the DUT should hold after each rising edge
logic                     m_run;
logic                     m_ext_enable;
logic                     m_sync;
logic                     m_tick;
logic                     m_tick_known;
logic [N_PWM-1:0]         m_stopped;
logic [N_PWM-1:0]         m_pwm_out;
logic [COUNTER_WIDTH-1:0] m_period [N_CHAINS];
logic [COUNTER_WIDTH-1:0] m_counter [N_CHAINS];
logic [COUNTER_WIDTH-1:0] m_compare_low [N_CHAINS][N_CHANNELS];
logic [COUNTER_WIDTH-1:0] m_compare_high [N_CHAINS][N_CHANNELS];

function automatic void model_reset();
    m_run = 1'b0;
    m_ext_enable = 1'b0;
    m_sync = 1'b0;
    // Tick is held low in reset, so it is known
    m_tick = 1'b0;
    m_tick_known = 1'b1;
    m_stopped = INITIAL_STOPPED_STATE;
    m_pwm_out = INITIAL_STOPPED_STATE;
    for (int k = 0; k < N_CHAINS; k++) begin
        m_period[k] = '0;
        m_counter[k] = '0;
        for (int c = 0; c < N_CHANNELS; c++) begin
            m_compare_low[k][c] = '0;
            m_compare_high[k][c] = '0;
        end
    end
endfunction

// Host write into the register map, block 0 is global and block k+1 is chain k
function automatic void model_write(input logic [7:0] address, input reg_word_u data);
    int block;
    int offset;
    int k;
    block = address[7:4];
    offset = address[3:0];
    k = block - 1;
    if (block == 0) begin
        if (offset == 0) begin
            m_run = data.control.run;
            m_ext_enable = data.control.ext_timebase_enable;
        end else if (offset == 1) begin
            m_stopped = data.raw[N_PWM-1:0];
        end
    end else if (block <= N_CHAINS) begin
        if (offset == 0) begin
            m_period[k] = data.raw[COUNTER_WIDTH-1:0];
        end else if (offset <= N_CHANNELS) begin
            m_compare_low[k][offset-1] = data.compare.compare_low;
            m_compare_high[k][offset-1] = data.compare.compare_high;
        end
    end
endfunction

// Expected pwm_out from the current counters, run, fault and stopped levels
function automatic logic [N_PWM-1:0] expected_pwm(input logic fault_in);
    logic [N_PWM-1:0] result;
    logic             in_window;
    logic             running;
    int               a_bit;
    result = '0;
    for (int k = 0; k < N_CHAINS; k++) begin
        // A chain with period 0 counts as halted
        running = m_run && (m_period[k] != 0);
        for (int c = 0; c < N_CHANNELS; c++) begin
            a_bit = k * N_CHANNELS + c;
            in_window = (m_counter[k] >= m_compare_low[k][c])
                && (m_counter[k] < m_compare_high[k][c]);
            if (fault_in || !running) begin
                result[a_bit] = m_stopped[a_bit];
                result[a_bit + HALF_PWM] = m_stopped[a_bit + HALF_PWM];
            end else begin
                result[a_bit] = in_window;
                result[a_bit + HALF_PWM] = !in_window;
            end
        end
    end
    return result;
endfunction

// One rising edge of the model, every result is built from the state before the edge
function automatic void model_step(input logic strobe, input logic [7:0] address,
                                   input reg_word_u data, input logic ext_in,
                                   input logic fault_in);
    logic [N_PWM-1:0] next_pwm;
    next_pwm = expected_pwm(fault_in);
    for (int k = 0; k < N_CHAINS; k++) begin
        if (m_sync) begin
            m_counter[k] = '0;
        end else if (m_tick && m_run && (m_period[k] != 0)) begin
            // Wrap from period-1 back to 0
            if (m_counter[k] + 1 >= m_period[k]) begin
                m_counter[k] = '0;
            end else begin
                m_counter[k] = m_counter[k] + 1'b1;
            end
        end
    end
    m_sync = strobe && (address == 8'h00) && data.control.sync;
    // The internal prescaler is not modeled, so the tick is only known from ext_timebase
    m_tick = m_ext_enable && ext_in;
    m_tick_known = m_ext_enable;
    if (strobe) begin
        model_write(address, data);
    end
    m_pwm_out = next_pwm;
endfunction

`endif

// ==== test/pwm_generator_tb.sv ====
// Testbench for the multi-channel PWM generator
// Random duty windows on the external timebase, then fault, halt, sync and divider checks
`timescale 1ns/1ps
`default_nettype none

module pwm_generator_tb
    import pwm_regs_pkg::*;
    import pwm_types_pkg::*;
();

    localparam int N_CHAINS = 2;
    localparam int N_CHANNELS = 2;
    localparam int COUNTER_WIDTH = 16;
    localparam int N_PWM = 2 * N_CHAINS * N_CHANNELS;
    localparam int HALF_PWM = N_PWM / 2;
    // Each a and b pair stops at equal levels that a running pair never shows
    localparam logic [N_PWM-1:0] INITIAL_STOPPED_STATE = 8'b1010_1010;
    localparam int CLOCK_PERIOD = 20;
    localparam int RESET_CYCLES = 10;

    // The planned stimulus also sizes the watchdog
    localparam int DUTY_TICKS = 40;
    localparam int FAULT_TICKS = 6;
    localparam int HALT_TICKS = 8;
    localparam int SYNC_TICKS = 20;
    localparam int PLANNED_TICKS = DUTY_TICKS + 3 * FAULT_TICKS + 4 * HALT_TICKS
        + 2 * SYNC_TICKS;
    localparam int PLANNED_WRITES = 24;
    // Four divider settings with at most 32 cycles between pulses
    localparam int DIVIDER_CYCLES = 4 * (4 * 32 + 12);
    // A tick pulse takes two cycles plus a gap of up to three
    localparam int WATCHDOG_CYCLES = 2 * (RESET_CYCLES + 2 * PLANNED_WRITES
        + 5 * PLANNED_TICKS + DIVIDER_CYCLES);

    logic             clock = 1'b0;
    logic             reset;
    logic             write_strobe;
    logic [7:0]       write_address;
    reg_word_u        write_data;
    logic             ext_timebase;
    logic             fault;
    logic             timebase;
    logic [N_PWM-1:0] pwm_out;
    logic             model_ready = 1'b0;
    logic [COUNTER_WIDTH-1:0] chain_period [N_CHAINS];

    `include "pwm_tb_model.svh"

    pwm_generator #(
        .N_CHAINS(N_CHAINS),
        .N_CHANNELS(N_CHANNELS),
        .COUNTER_WIDTH(COUNTER_WIDTH),
        .INITIAL_STOPPED_STATE(INITIAL_STOPPED_STATE)
    ) uut (
        .clock(clock),
        .reset(reset),
        .write_strobe(write_strobe),
        .write_address(write_address),
        .write_data(write_data),
        .ext_timebase(ext_timebase),
        .fault(fault),
        .timebase(timebase),
        .pwm_out(pwm_out)
    );

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_pwm(input logic [N_PWM-1:0] expected, input logic [N_PWM-1:0] actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("FAILED at %0t: pwm_out expected %b, got %b",
                $time, expected, actual));
        end
    endtask

    task automatic check_tick(input logic expected, input logic actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("FAILED at %0t: timebase expected %b, got %b",
                $time, expected, actual));
        end
    endtask

    function automatic reg_word_u data_word(input logic [31:0] value);
        reg_word_u word;
        word.raw = value;
        return word;
    endfunction

    function automatic reg_word_u control_word(input logic run, input logic sync,
                                               input logic ext_enable, input divider_t divider);
        reg_word_u word;
        word.raw = '0;
        word.control.run = run;
        word.control.sync = sync;
        word.control.ext_timebase_enable = ext_enable;
        word.control.divider = divider;
        return word;
    endfunction

    function automatic reg_word_u compare_word(input logic [15:0] low, input logic [15:0] high);
        reg_word_u word;
        word.compare.compare_low = low;
        word.compare.compare_high = high;
        return word;
    endfunction

    // Chain k answers at block k+1
    function automatic logic [7:0] chain_address(input int k, input reg_offset_t offset);
        return {4'(k + 1), offset};
    endfunction

    task automatic write_reg(input logic [7:0] address, input reg_word_u data);
        @(posedge clock);
        write_strobe <= 1'b1;
        write_address <= address;
        write_data <= data;
        @(posedge clock);
        write_strobe <= 1'b0;
    endtask

    // One-cycle pulses on ext_timebase with a random idle gap between them
    task automatic pulse_ext(input int count);
        int gap;
        for (int i = 0; i < count; i++) begin
            @(posedge clock);
            ext_timebase <= 1'b1;
            @(posedge clock);
            ext_timebase <= 1'b0;
            gap = draw_bits(2);
            repeat (gap) @(posedge clock);
        end
    endtask

    // On the internal timebase the pulses must come exactly every 2^divider cycles
    task automatic check_divider(input divider_t divider);
        int spacing;
        int waited;
        spacing = 1 << divider;
        write_reg({block_control, reg_control}, control_word(1'b0, 1'b0, 1'b0, divider));
        // Let the new divider settle before measuring
        repeat (spacing + 4) @(negedge clock);
        waited = 0;
        while (timebase !== 1'b1) begin
            if (waited > spacing) begin
                stop_with_failure($sformatf("No timebase pulse within %0d cycles at divider %0d",
                    spacing + 1, divider));
            end
            waited++;
            @(negedge clock);
        end
        for (int i = 1; i <= 2 * spacing; i++) begin
            @(negedge clock);
            check_tick((i % spacing) == 0, timebase);
        end
    endtask

    // Reference model steps on the same edge as the DUT with the inputs the DUT samples
    always @(posedge clock) begin
        if (!reset) begin
            model_reset();
        end else begin
            model_step(write_strobe, write_address, write_data, ext_timebase, fault);
        end
        model_ready = 1'b1;
    end

    // Outputs are compared on the falling edge while they are stable
    always @(negedge clock) begin
        if (model_ready) begin
            check_pwm(m_pwm_out, pwm_out);
            if (m_tick_known) begin
                check_tick(m_tick, timebase);
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLOCK_PERIOD);
        stop_with_failure("Watchdog expired before the test sequence finished");
    end

    initial begin
        int period;
        int low;
        int high;
        logic [HALF_PWM-1:0] stopped_half;
        reset = 1'b0;
        write_strobe = 1'b0;
        write_address = '0;
        write_data = '0;
        ext_timebase = 1'b0;
        fault = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b1;

        // State left by the last reset edge
        @(negedge clock);
        check_pwm(INITIAL_STOPPED_STATE, pwm_out);
        check_tick(1'b0, timebase);

        // Random periods and windows counted on the external timebase
        write_reg({block_control, reg_control}, control_word(1'b0, 1'b0, 1'b1, 3'd0));
        for (int k = 0; k < N_CHAINS; k++) begin
            period = 4 + draw_bits(4);
            chain_period[k] = 16'(period);
            write_reg(chain_address(k, reg_period), data_word(32'(period)));
            for (int c = 0; c < N_CHANNELS; c++) begin
                low = draw_bits(5) % period;
                high = low + draw_bits(5) % (period - low + 1);
                write_reg(chain_address(k, reg_offset_t'(reg_compare_base + c)),
                    compare_word(16'(low), 16'(high)));
            end
        end
        write_reg({block_control, reg_control}, control_word(1'b1, 1'b0, 1'b1, 3'd0));
        pulse_ext(DUTY_TICKS);

        // Fault forces the stopped levels and new levels are written while it is high
        pulse_ext(FAULT_TICKS);
        @(posedge clock);
        fault <= 1'b1;
        pulse_ext(FAULT_TICKS);
        // The same random level goes to output a and output b of each pair
        stopped_half = HALF_PWM'(draw_bits(HALF_PWM));
        write_reg({block_control, reg_stopped}, data_word(32'({stopped_half, stopped_half})));
        @(posedge clock);
        fault <= 1'b0;
        pulse_ext(FAULT_TICKS);

        // Chain 1 is halted by period 0 while chain 0 runs and then both are halted by run
        write_reg(chain_address(1, reg_period), data_word(32'h0));
        pulse_ext(HALT_TICKS);
        write_reg(chain_address(1, reg_period), data_word(32'(chain_period[1])));
        pulse_ext(HALT_TICKS);
        write_reg({block_control, reg_control}, control_word(1'b0, 1'b0, 1'b1, 3'd0));
        pulse_ext(HALT_TICKS);
        write_reg({block_control, reg_control}, control_word(1'b1, 1'b0, 1'b1, 3'd0));
        pulse_ext(HALT_TICKS);

        // Sync restarts every counter from 0
        pulse_ext(SYNC_TICKS);
        write_reg({block_control, reg_control}, control_word(1'b1, 1'b1, 1'b1, 3'd0));
        pulse_ext(SYNC_TICKS);

        // Internal timebase at several divider settings
        check_divider(3'd0);
        check_divider(3'd1);
        check_divider(3'd2);
        check_divider(3'd5);

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/pwm_generator.sv ====
// Multi-channel PWM generator top level
// Connects the control unit, timebase, chains and output stage
`timescale 1ns/1ps
`default_nettype none

module pwm_generator
    import pwm_types_pkg::*;
#(
    parameter int N_CHAINS = 2,
    parameter int N_CHANNELS = 2,
    parameter int COUNTER_WIDTH = 16,
    parameter logic [2*N_CHAINS*N_CHANNELS-1:0] INITIAL_STOPPED_STATE = '0
) (
    input  wire logic        clock,
    input  wire logic        reset,
    input  wire logic        write_strobe,
    input  wire logic [7:0]  write_address,
    input  wire logic [31:0] write_data,
    input  wire logic        ext_timebase,
    input  wire logic        fault,
    output logic             timebase,
    output logic [2*N_CHAINS*N_CHANNELS-1:0] pwm_out
);

    localparam int N_PWM = 2 * N_CHAINS * N_CHANNELS;

    divider_t                     divider;
    logic                         ext_timebase_enable;
    logic [N_PWM-1:0]             stopped_state;
    logic                         tick;
    chain_status_t [N_CHAINS-1:0] chain_status;
    logic [N_PWM-1:0]             raw_pwm;

    pwm_ctrl_if #(.N_CHAINS(N_CHAINS)) ctrl_bus ();

    pwm_control_unit #(
        .N_CHAINS(N_CHAINS),
        .N_PWM(N_PWM),
        .INITIAL_STOPPED_STATE(INITIAL_STOPPED_STATE)
    ) control_unit (
        .clock(clock),
        .reset(reset),
        .write_strobe(write_strobe),
        .write_address(write_address),
        .write_data(write_data),
        .ctrl(ctrl_bus),
        .divider(divider),
        .ext_timebase_enable(ext_timebase_enable),
        .stopped_state(stopped_state)
    );

    timebase_generator timebase_gen (
        .clock(clock),
        .reset(reset),
        .divider(divider),
        .ext_timebase_enable(ext_timebase_enable),
        .ext_timebase(ext_timebase),
        .tick(tick)
    );

    // The tick reaches the chains over the control bus and is also visible outside
    assign ctrl_bus.tick = tick;
    assign timebase = tick;

    // Chain k fills bits k*N_CHANNELS of each half of raw_pwm
    for (genvar k = 0; k < N_CHAINS; k++) begin : gen_chain
        pwm_chain #(
            .CHAIN_INDEX(k),
            .N_CHANNELS(N_CHANNELS),
            .COUNTER_WIDTH(COUNTER_WIDTH)
        ) chain (
            .clock(clock),
            .reset(reset),
            .ctrl(ctrl_bus),
            .status(chain_status[k]),
            .out_a(raw_pwm[k*N_CHANNELS +: N_CHANNELS]),
            .out_b(raw_pwm[N_CHAINS*N_CHANNELS + k*N_CHANNELS +: N_CHANNELS])
        );
    end

    pwm_output_stage #(
        .N_PWM(N_PWM),
        .N_CHAINS(N_CHAINS),
        .INITIAL_STOPPED_STATE(INITIAL_STOPPED_STATE)
    ) output_stage (
        .clock(clock),
        .reset(reset),
        .chain_status(chain_status),
        .fault(fault),
        .raw_pwm(raw_pwm),
        .stopped_state(stopped_state),
        .pwm_out(pwm_out)
    );

endmodule

`default_nettype wire

// ==== src/pwm_output_stage.sv ====
// PWM output stage
// Registers raw outputs per chain, or the stopped levels while halted or faulted
`timescale 1ns/1ps
`default_nettype none

module pwm_output_stage
    import pwm_types_pkg::*;
#(
    parameter int N_PWM = 8,
    parameter int N_CHAINS = 2,
    parameter logic [N_PWM-1:0] INITIAL_STOPPED_STATE = '0
) (
    input  wire logic                       clock,
    input  wire logic                       reset,
    input  wire chain_status_t [N_CHAINS-1:0] chain_status,
    input  wire logic                       fault,
    input  wire logic [N_PWM-1:0]           raw_pwm,
    input  wire logic [N_PWM-1:0]           stopped_state,
    output logic [N_PWM-1:0]                pwm_out
);

    // Outputs a fill the lower half and outputs b the upper half, N_CHANNELS per chain
    localparam int HALF_WIDTH = N_PWM / 2;
    localparam int PER_CHAIN = HALF_WIDTH / N_CHAINS;

    logic [N_PWM-1:0] live;

    // Mark each output bit whose chain is running
    always_comb begin
        for (int i = 0; i < N_PWM; i++) begin
            live[i] = chain_status[(i % HALF_WIDTH) / PER_CHAIN];
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            pwm_out <= INITIAL_STOPPED_STATE;
        end else if (fault) begin
            // Fault overrides every chain at once
            pwm_out <= stopped_state;
        end else begin
            pwm_out <= (raw_pwm & live) | (stopped_state & ~live);
        end
    end

endmodule

`default_nettype wire

// ==== src/pwm_chain.sv ====
// PWM chain
// One period counter shared by N_CHANNELS compare channels, each with a complementary pair
`timescale 1ns/1ps
`default_nettype none

module pwm_chain
    import pwm_regs_pkg::*;
    import pwm_types_pkg::*;
#(
    parameter int CHAIN_INDEX = 0,
    parameter int N_CHANNELS = 2,
    parameter int COUNTER_WIDTH = 16
) (
    input  wire logic            clock,
    input  wire logic            reset,
    pwm_ctrl_if.chain            ctrl,
    output chain_status_t        status,
    output logic [N_CHANNELS-1:0] out_a,
    output logic [N_CHANNELS-1:0] out_b
);

    logic [COUNTER_WIDTH-1:0] period;
    logic [COUNTER_WIDTH-1:0] counter;
    logic [COUNTER_WIDTH-1:0] compare_low [N_CHANNELS];
    logic [COUNTER_WIDTH-1:0] compare_high [N_CHANNELS];
    logic                     chain_write;

    // This chain's slice of the register map
    assign chain_write = ctrl.write_strobe && ctrl.chain_select[CHAIN_INDEX];

    // Period and compare registers
    always_ff @(posedge clock) begin
        if (!reset) begin
            period <= '0;
            for (int c = 0; c < N_CHANNELS; c++) begin
                compare_low[c] <= '0;
                compare_high[c] <= '0;
            end
        end else if (chain_write) begin
            if (ctrl.write_offset == reg_period) begin
                period <= ctrl.write_data.raw[COUNTER_WIDTH-1:0];
            end
            for (int c = 0; c < N_CHANNELS; c++) begin
                // Compare words use the two 16-bit halves of the union
                if (ctrl.write_offset == reg_offset_t'(reg_compare_base + c)) begin
                    compare_low[c] <= ctrl.write_data.compare.compare_low[COUNTER_WIDTH-1:0];
                    compare_high[c] <= ctrl.write_data.compare.compare_high[COUNTER_WIDTH-1:0];
                end
            end
        end
    end

    // A chain with period 0 has nothing to count and reports halted
    assign status = ctrl.run && (period != '0);

    // Period counter, sync wins over counting
    always_ff @(posedge clock) begin
        if (!reset) begin
            counter <= '0;
        end else if (ctrl.sync) begin
            counter <= '0;
        end else if (ctrl.tick && status) begin
            // Wrap at period-1, also catches a period shortened below the counter
            if (counter >= period - 1'b1) begin
                counter <= '0;
            end else begin
                counter <= counter + 1'b1;
            end
        end
    end

    // Output a is high inside the window [compare_low, compare_high)
    always_comb begin
        for (int c = 0; c < N_CHANNELS; c++) begin
            out_a[c] = (counter >= compare_low[c]) && (counter < compare_high[c]);
            out_b[c] = !out_a[c];
        end
    end

endmodule

`default_nettype wire

// ==== src/timebase_generator.sv ====
// Timebase generator
// Divides the clock by 2^divider or follows the external timebase, with a registered tick
`timescale 1ns/1ps
`default_nettype none

module timebase_generator
    import pwm_types_pkg::*;
(
    input  wire logic clock,
    input  wire logic reset,
    input  wire divider_t divider,
    input  wire logic ext_timebase_enable,
    input  wire logic ext_timebase,
    output logic      tick
);

    // Wide enough for the largest divider setting
    localparam int PRESCALE_WIDTH = 2 ** $bits(divider_t) - 1;

    logic [PRESCALE_WIDTH-1:0] prescaler;
    logic [PRESCALE_WIDTH-1:0] prescale_mask;
    logic                      internal_pulse;

    // Low divider bits of the prescaler, all ones once every 2^divider cycles
    assign prescale_mask = PRESCALE_WIDTH'((1 << divider) - 1);
    assign internal_pulse = (prescaler & prescale_mask) == prescale_mask;

    // Free-running prescaler
    always_ff @(posedge clock) begin
        if (!reset) begin
            prescaler <= '0;
        end else begin
            prescaler <= prescaler + 1'b1;
        end
    end

    // Source selection goes through one register in both modes
    always_ff @(posedge clock) begin
        if (!reset) begin
            tick <= 1'b0;
        end else if (ext_timebase_enable) begin
            tick <= ext_timebase;
        end else begin
            tick <= internal_pulse;
        end
    end

endmodule

`default_nettype wire

// ==== src/pwm_control_unit.sv ====
// PWM control unit
// Decodes host writes, holds the global settings and forwards chain writes
`timescale 1ns/1ps
`default_nettype none

module pwm_control_unit
    import pwm_regs_pkg::*;
    import pwm_types_pkg::*;
#(
    parameter int N_CHAINS = 2,
    parameter int N_PWM = 8,
    parameter logic [N_PWM-1:0] INITIAL_STOPPED_STATE = '0
) (
    input  wire logic       clock,
    input  wire logic       reset,
    input  wire logic       write_strobe,
    input  wire logic [7:0] write_address,
    input  wire reg_word_u  write_data,
    pwm_ctrl_if.control     ctrl,
    output divider_t        divider,
    output logic            ext_timebase_enable,
    output logic [N_PWM-1:0] stopped_state
);

    reg_block_t  block;
    reg_offset_t offset;
    logic        control_write;
    logic        run;
    logic        sync_pulse;

    // Upper nibble picks the block, lower nibble the register inside it
    assign block = write_address[7:4];
    assign offset = write_address[3:0];

    // A write to block 0 belongs to this unit, anything else goes to a chain
    assign control_write = write_strobe && (block == block_control);

    // Global registers, updated in the cycle after the strobe
    always_ff @(posedge clock) begin
        if (!reset) begin
            run <= 1'b0;
            divider <= '0;
            ext_timebase_enable <= 1'b0;
            stopped_state <= INITIAL_STOPPED_STATE;
        end else if (control_write) begin
            if (offset == reg_control) begin
                run <= write_data.control.run;
                divider <= write_data.control.divider;
                ext_timebase_enable <= write_data.control.ext_timebase_enable;
            end
            if (offset == reg_stopped) begin
                // Only the low N_PWM bits map to outputs
                stopped_state <= write_data.raw[N_PWM-1:0];
            end
        end
    end

    // Sync is a write-one pulse, it lasts exactly one cycle and is never held
    always_ff @(posedge clock) begin
        if (!reset) begin
            sync_pulse <= 1'b0;
        end else begin
            sync_pulse <= control_write && (offset == reg_control) && write_data.control.sync;
        end
    end

    assign ctrl.run = run;
    assign ctrl.sync = sync_pulse;

    // Chain writes pass straight through so the chain registers them in the same edge
    assign ctrl.write_strobe = write_strobe && (block != block_control);
    assign ctrl.write_offset = offset;
    assign ctrl.write_data = write_data;

    // One-hot select, chain k answers at block k+1
    always_comb begin
        for (int k = 0; k < N_CHAINS; k++) begin
            ctrl.chain_select[k] = write_strobe && (block == reg_block_t'(k + 1));
        end
    end

endmodule

`default_nettype wire

// ==== src/pwm_ctrl_if.sv ====
// Control bus from the PWM control unit to the chains
// Carries run, sync, the counting tick and the decoded chain writes
`timescale 1ns/1ps
`default_nettype none

interface pwm_ctrl_if
    import pwm_regs_pkg::*;
#(
    parameter int N_CHAINS = 2
);

    // Global counting controls
    logic run;
    logic sync;
    logic tick;

    // Chain register write, chain_select is one-hot and only set with write_strobe
    logic                write_strobe;
    reg_offset_t         write_offset;
    reg_word_u           write_data;
    logic [N_CHAINS-1:0] chain_select;

    modport control (
        output run,
        output sync,
        output write_strobe,
        output write_offset,
        output write_data,
        output chain_select
    );

    modport chain (
        input run,
        input sync,
        input tick,
        input write_strobe,
        input write_offset,
        input write_data,
        input chain_select
    );

endinterface

`default_nettype wire

// ==== src/pwm_types_pkg.sv ====
// PWM datapath types
// Shared between the control unit, timebase, chains and output stage
`default_nettype none

package pwm_types_pkg;

    // Prescaler setting, the tick period is 2 to the power of this value in clocks
    typedef logic [2:0] divider_t;

    // Status of a single chain, high while the chain is counting
    // Vectors over all chains are built as packed arrays of this type
    typedef logic chain_status_t;

endpackage

`default_nettype wire

// ==== src/pwm_regs_pkg.sv ====
// PWM register map
// Holds the block and offset constants and the decoded views of the 32-bit register word
`default_nettype none

package pwm_regs_pkg;

    // The upper address nibble selects a block and the lower nibble selects a register
    typedef logic [3:0] reg_block_t;
    typedef logic [3:0] reg_offset_t;

    // Block 0 is the control unit and chain k answers at block k+1
    localparam reg_block_t block_control = 4'd0;

    // Registers inside the control block
    localparam reg_offset_t reg_control = 4'd0;
    localparam reg_offset_t reg_stopped = 4'd1;

    // Registers inside a chain block, channel c sits at reg_compare_base + c
    localparam reg_offset_t reg_period = 4'd0;
    localparam reg_offset_t reg_compare_base = 4'd1;

    // Global control word, run sits in bit 0
    typedef struct packed {
        logic [25:0] reserved;
        logic [2:0]  divider;
        logic        ext_timebase_enable;
        logic        sync;
        logic        run;
    } control_word_t;

    // Compare window of one channel
    typedef struct packed {
        logic [15:0] compare_high;
        logic [15:0] compare_low;
    } compare_word_t;

    // The same host word read as a control word, a compare word or raw bits
    typedef union packed {
        control_word_t control;
        compare_word_t compare;
        logic [31:0]   raw;
    } reg_word_u;

endpackage

`default_nettype wire
